/* source/lsu_access_pkg.sv */
// execute-stage access description
// access size, upper-bit fill mode and byte offset types

package lsu_access_pkg;

  ////////////////////
  // access size
  ////////////////////

  // 2'b11 is not named, decoders treat it like a byte
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } access_size_e;

  ////////////////////
  // load fill mode
  ////////////////////

  // 2'b11 is not named either, it falls back to sign fill
  typedef enum logic [1:0] {
    FILL_ZERO = 2'b00, // upper bits cleared
    FILL_SIGN = 2'b01, // upper bits copy the msb of the loaded field
    FILL_ONES = 2'b10  // upper bits set
  } fill_mode_e;

  typedef logic [1:0] byte_off_t; // byte position inside a word

endpackage

/* source/lsu_bus_pkg.sv */
// data memory bus description
// widths, address, data and byte-enable types, read word views

package lsu_bus_pkg;

  localparam int unsigned DATA_W = 32;         // data bus width
  localparam int unsigned NUM_BE = DATA_W / 8; // byte lanes

  typedef logic [31:0]       addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [NUM_BE-1:0] be_t;

  ////////////////////
  // read word views
  ////////////////////

  // the same read word seen as lanes or as halfwords
  typedef union packed {
    logic [NUM_BE-1:0][7:0]    bytes;  // bytes[0] is the lowest lane
    logic [NUM_BE/2-1:0][15:0] halves; // halves[1] holds lanes 3 and 2
  } rdata_word_u;

endpackage

/* source/lsu_load_ctx_if.sv */
// granted access context
// carries size, offset, fill, direction and a pending-load flag
// from bus control to load alignment

`timescale 1ns/1ns

interface lsu_load_ctx_if import lsu_access_pkg::*; ();

  access_size_e size;     // size of the granted access
  byte_off_t    offset;   // low address bits of the granted access
  fill_mode_e   fill;     // fill mode for the loaded field
  logic         we;       // granted access was a store
  logic         captured; // a load waits for its rvalid

  // bus control owns the context register
  modport ctrl (
    output size, offset, fill, we, captured
  );

  // load alignment only reads it
  modport align (
    input size, offset, fill, we, captured
  );

endinterface

/* source/lsu_addr_store.sv */
// address generation and misalignment detection
// byte-enable generation and store data rotation

`timescale 1ns/1ns

module lsu_addr_store import lsu_access_pkg::*, lsu_bus_pkg::*; (
  input  word_t        operand_a_i,   // base from register file
  input  word_t        operand_b_i,   // offset from register file
  input  logic         use_incr_i,    // address is a + b instead of a
  input  access_size_e size_i,
  input  byte_off_t    reg_offset_i,  // byte position of the data in the register
  input  word_t        wdata_i,
  input  logic         req_i,
  input  logic         second_part_i, // second beat of a misaligned access
  output addr_t        addr_o,
  output be_t          be_o,
  output word_t        wdata_o,
  output logic         misaligned_o   // access needs a second beat
);

  byte_off_t               addr_off;  // lane of the first byte
  byte_off_t               wdata_off; // store data rotation in bytes
  logic [2*DATA_W-1:0]     wdata_rot;

  assign addr_o   = use_incr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_off = addr_o[1:0];

  // only the first part can cross a word boundary
  always_comb
  begin
    misaligned_o = 1'b0;
    if (req_i && !second_part_i)
    begin
      case (size_i)
        SIZE_WORD: misaligned_o = (addr_off != 2'b00);
        SIZE_HALF: misaligned_o = (addr_off == 2'b11);
        default:   misaligned_o = 1'b0; // bytes never cross
      endcase
    end
  end

  ////////////////////
  // byte enables
  ////////////////////

  always_comb
  begin
    case (size_i)
      SIZE_WORD:
      begin
        if (second_part_i)
          be_o = be_t'((4'b0001 << addr_off) - 4'b0001); // lanes below the offset
        else
          be_o = be_t'(4'b1111 << addr_off);              // offset and up
      end
      SIZE_HALF:
      begin
        if (second_part_i)
          be_o = 4'b0001;                 // spill of offset 3 lands in lane 0
        else
          be_o = be_t'(4'b0011 << addr_off); // offset 3 keeps lane 3 only
      end
      default: be_o = be_t'(4'b0001 << addr_off);
    endcase
  end

  ////////////////////
  // store data
  ////////////////////

  // rotate left so register byte reg_offset lands on lane addr_off
  assign wdata_off = addr_off - reg_offset_i; // wraps modulo 4
  assign wdata_rot = {wdata_i, wdata_i} << (8 * wdata_off);
  assign wdata_o   = wdata_rot[2*DATA_W-1:DATA_W];

  // a request with an unresolved address would hit a random location
  always_comb
  begin
    if (req_i)
    begin
      a_addr_known: assert (!$isunknown(addr_o))
        else $error("lsu: request with unknown address");
    end
  end

endmodule

/* source/lsu_bus_ctrl.sv */
// memory bus request controller, idle and wait-for-rvalid states
// context register loaded on every grant
// ready, stall and busy outputs

`timescale 1ns/1ns

module lsu_bus_ctrl import lsu_access_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         req_i,      // request from execute
  input  logic         we_i,
  input  access_size_e size_i,
  input  fill_mode_e   fill_i,
  input  byte_off_t    addr_lo_i,  // low address bits of the current access
  input  logic         gnt_i,
  input  logic         rvalid_i,
  output logic         req_o,      // request to memory
  output logic         ready_ex_o, // execute may move on
  output logic         ready_wb_o, // writeback may move on
  output logic         busy_o,
  lsu_load_ctx_if.ctrl ctx
);

  typedef enum logic {
    IDLE,
    WAIT_RVALID
  } state_e;

  state_e state_q;
  state_e state_d;

  ////////////////////
  // next state
  ////////////////////

  always_comb
  begin
    state_d    = state_q;
    req_o      = 1'b0;
    ready_wb_o = 1'b1;
    case (state_q)
      IDLE:
      begin
        req_o = req_i; // pass request straight through
        if (req_i && gnt_i)
          state_d = WAIT_RVALID;
      end
      WAIT_RVALID:
      begin
        ready_wb_o = rvalid_i; // writeback stalls until data is back
        if (rvalid_i)
        begin
          req_o   = req_i;                         // next access overlaps the data phase
          state_d = (req_i && gnt_i) ? WAIT_RVALID : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign ready_ex_o = !(req_o && !gnt_i); // low only while request not granted
  assign busy_o     = (state_q == WAIT_RVALID) || req_o;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////
  // access context
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctx.size     <= SIZE_WORD;
      ctx.offset   <= '0;
      ctx.fill     <= FILL_ZERO;
      ctx.we       <= 1'b0;
      ctx.captured <= 1'b0;
    end
    else if (gnt_i)
    begin
      ctx.size     <= size_i;    // snapshot of the granted access
      ctx.offset   <= addr_lo_i;
      ctx.fill     <= fill_i;
      ctx.we       <= we_i;
      ctx.captured <= !we_i;     // only loads wait for data
    end
    else if (rvalid_i)
      ctx.captured <= 1'b0;      // data phase done, nothing new granted
  end

  // the bus answers only what was granted
  a_no_rvalid_idle: assert property (
    @(posedge clk) disable iff (!rst_n) (state_q == IDLE) |-> !rvalid_i
  ) else $error("lsu: rvalid while idle");

  // a new grant must not run ahead of the outstanding data phase
  a_gnt_with_rvalid: assert property (
    @(posedge clk) disable iff (!rst_n) ((state_q == WAIT_RVALID) && gnt_i) |-> rvalid_i
  ) else $error("lsu: grant while waiting without rvalid");

endmodule

/* source/lsu_load_align.sv */
// read data alignment for words, halfwords and bytes
// zero, ones or sign fill of the upper bits
// misaligned load assembly from two beats and the held result register

`timescale 1ns/1ns

module lsu_load_align import lsu_access_pkg::*, lsu_bus_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  word_t         rdata_i,       // raw word from memory
  input  logic          rvalid_i,
  input  logic          second_part_i, // execute presents a second beat
  input  logic          misaligned_i,  // execute presents a first beat
  lsu_load_ctx_if.align ctx,
  output word_t         rdata_o        // extended result to execute
);

  rdata_word_u cur_u;    // current beat
  rdata_word_u held_u;   // first beat of a misaligned access
  word_t       rdata_q;
  word_t       word_val;
  logic [15:0] half_val;
  logic [7:0]  byte_val;
  word_t       rdata_ext;
  logic        load_beat;

  function automatic logic fill_bit(fill_mode_e mode, logic msb);
    case (mode)
      FILL_ZERO: return 1'b0;
      FILL_ONES: return 1'b1;
      default:   return msb; // sign fill, also for 2'b11
    endcase
  endfunction

  assign cur_u     = rdata_i;
  assign held_u    = rdata_q;
  assign load_beat = rvalid_i && ctx.captured && !ctx.we;

  ////////////////////
  // extraction
  ////////////////////

  // high bytes of a crossing access come from the current beat
  always_comb
  begin
    case (ctx.offset)
      2'b00: word_val = rdata_i;
      2'b01: word_val = {cur_u.bytes[0], held_u.bytes[3:1]};
      2'b10: word_val = {cur_u.halves[0], held_u.halves[1]};
      2'b11: word_val = {cur_u.bytes[2:0], held_u.bytes[3]};
    endcase
    case (ctx.offset)
      2'b00: half_val = cur_u.halves[0];
      2'b01: half_val = {cur_u.bytes[2], cur_u.bytes[1]};
      2'b10: half_val = cur_u.halves[1];
      2'b11: half_val = {cur_u.bytes[0], held_u.bytes[3]}; // spans two beats
    endcase
    byte_val = cur_u.bytes[ctx.offset];
  end

  always_comb
  begin
    case (ctx.size)
      SIZE_WORD: rdata_ext = word_val;
      SIZE_HALF: rdata_ext = {{16{fill_bit(ctx.fill, half_val[15])}}, half_val};
      default:   rdata_ext = {{24{fill_bit(ctx.fill, byte_val[7])}}, byte_val};
    endcase
  end

  ////////////////////
  // held result
  ////////////////////

  // the first beat's data returns while execute already shows the second part
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (load_beat)
    begin
      if (second_part_i || misaligned_i)
        rdata_q <= rdata_i;   // keep raw word for assembly
      else
        rdata_q <= rdata_ext; // final value, held for execute
    end
  end

  assign rdata_o = load_beat ? rdata_ext : rdata_q;

endmodule

/* source/lsu_top.sv */
// load/store unit top level
// address and store formatting, bus control and load alignment
// joined by the access context interface

`timescale 1ns/1ns

module lsu_top import lsu_access_pkg::*, lsu_bus_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  // data memory bus
  output logic       data_req_o,
  input  logic       data_gnt_i,
  input  logic       data_rvalid_i,
  output addr_t      data_addr_o,
  output logic       data_we_o,
  output be_t        data_be_o,
  output word_t      data_wdata_o,
  input  word_t      data_rdata_i,
  // execute stage
  input  logic       data_we_ex_i,
  input  logic [1:0] data_type_ex_i,       // word, half or byte
  input  word_t      data_wdata_ex_i,
  input  logic [1:0] data_reg_offset_ex_i, // store byte position in the register
  input  logic [1:0] data_sign_ext_ex_i,   // fill mode for loads
  output word_t      data_rdata_ex_o,
  input  logic       data_req_ex_i,
  input  word_t      operand_a_ex_i,
  input  word_t      operand_b_ex_i,
  input  logic       addr_useincr_ex_i,
  input  logic       data_misaligned_ex_i, // second part of a split access
  output logic       data_misaligned_o,    // a split access was found
  // stalls
  output logic       lsu_ready_ex_o,
  output logic       lsu_ready_wb_o,
  output logic       busy_o
);

  addr_t addr;       // access address, low bits feed the context
  logic  misaligned; // first part of a split access

  lsu_load_ctx_if ctx_if ();

  lsu_addr_store u_addr_store (
    .operand_a_i  (operand_a_ex_i),
    .operand_b_i  (operand_b_ex_i),
    .use_incr_i   (addr_useincr_ex_i),
    .size_i       (access_size_e'(data_type_ex_i)),
    .reg_offset_i (data_reg_offset_ex_i),
    .wdata_i      (data_wdata_ex_i),
    .req_i        (data_req_ex_i),
    .second_part_i(data_misaligned_ex_i),
    .addr_o       (addr),
    .be_o         (data_be_o),
    .wdata_o      (data_wdata_o),
    .misaligned_o (misaligned)
  );

  lsu_bus_ctrl u_bus_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (data_req_ex_i),
    .we_i      (data_we_ex_i),
    .size_i    (access_size_e'(data_type_ex_i)),
    .fill_i    (fill_mode_e'(data_sign_ext_ex_i)),
    .addr_lo_i (addr[1:0]),
    .gnt_i     (data_gnt_i),
    .rvalid_i  (data_rvalid_i),
    .req_o     (data_req_o),
    .ready_ex_o(lsu_ready_ex_o),
    .ready_wb_o(lsu_ready_wb_o),
    .busy_o    (busy_o),
    .ctx       (ctx_if.ctrl)
  );

  lsu_load_align u_load_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .rdata_i      (data_rdata_i),
    .rvalid_i     (data_rvalid_i),
    .second_part_i(data_misaligned_ex_i),
    .misaligned_i (misaligned),
    .ctx          (ctx_if.align),
    .rdata_o      (data_rdata_ex_o)
  );

  assign data_addr_o       = addr;
  assign data_misaligned_o = misaligned;
  assign data_we_o         = data_we_ex_i; // direction goes straight to the bus

endmodule

/* verification/tb_clock_gen.sv */
// testbench clock and reset source
// 4 ns clock, reset held low for two rising edges

`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o; // 2 ns half period
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 rst_n_o = 1'b1; // release away from the edge
  end

endmodule

/* verification/tb_lsu.sv */
// load/store unit testbench
// byte memory model with random grant delay, stimulus table
// compare tasks, timeout and final verdict

`timescale 1ns/1ns

module tb_lsu import lsu_access_pkg::*, lsu_bus_pkg::*; ();

  localparam int NUM_ENTRIES = 20;
  localparam int LIMIT = NUM_ENTRIES * 8; // a split access needs at most 8 cycles

  typedef struct {
    string      name;
    bit         we;
    word_t      op_a;
    word_t      op_b;
    bit         incr;
    logic [1:0] size;
    logic [1:0] fill;
    byte_off_t  reg_off;
    word_t      wdata;
    bit         mis;     // expected misaligned flag of the first part
  } entry_t;

  logic       clk;
  logic       rst_n;
  logic       data_req;
  logic       data_gnt;
  logic       data_rvalid;
  addr_t      data_addr;
  logic       data_we;
  be_t        data_be;
  word_t      data_wdata;
  word_t      data_rdata;
  logic       we_ex;
  logic [1:0] type_ex;
  word_t      wdata_ex;
  logic [1:0] reg_off_ex;
  logic [1:0] sign_ext_ex;
  word_t      rdata_ex;
  logic       req_ex;
  word_t      op_a_ex;
  word_t      op_b_ex;
  logic       useincr_ex;
  logic       mis_ex;
  logic       mis_o;
  logic       ready_ex;
  logic       ready_wb;
  logic       busy;

  logic [7:0] mem [0:63];          // model storage
  entry_t     tbl [NUM_ENTRIES];
  int         delay_left = 0;      // idle cycles before next grant
  bit         take;
  bit         req_seen;
  word_t      rd_next;
  bit         any_fail = 1'b0;

  tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

  lsu_top DUT (
    .clk(clk), .rst_n(rst_n),
    .data_req_o(data_req), .data_gnt_i(data_gnt), .data_rvalid_i(data_rvalid),
    .data_addr_o(data_addr), .data_we_o(data_we), .data_be_o(data_be),
    .data_wdata_o(data_wdata), .data_rdata_i(data_rdata),
    .data_we_ex_i(we_ex), .data_type_ex_i(type_ex), .data_wdata_ex_i(wdata_ex),
    .data_reg_offset_ex_i(reg_off_ex), .data_sign_ext_ex_i(sign_ext_ex),
    .data_rdata_ex_o(rdata_ex), .data_req_ex_i(req_ex),
    .operand_a_ex_i(op_a_ex), .operand_b_ex_i(op_b_ex),
    .addr_useincr_ex_i(useincr_ex), .data_misaligned_ex_i(mis_ex),
    .data_misaligned_o(mis_o), .lsu_ready_ex_o(ready_ex),
    .lsu_ready_wb_o(ready_wb), .busy_o(busy)
  );

  ////////////////////
  // memory model
  ////////////////////

  assign data_gnt = data_req && (delay_left == 0);

  always @(posedge clk)
  begin
    take     = rst_n && data_req && data_gnt; // sampled before the DUT updates
    req_seen = data_req;
    if (take)
    begin
      for (int l = 0; l < 4; l++)
      begin
        if (data_we && data_be[l])
          mem[{data_addr[5:2], 2'(l)}] = data_wdata[8*l +: 8]; // write on grant
        rd_next[8*l +: 8] = mem[{data_addr[5:2], 2'(l)}];
      end
    end
    #1;
    data_rvalid = take; // exactly one cycle after grant
    if (take)
    begin
      data_rdata = rd_next;
      delay_left = $urandom_range(2, 0);
    end
    else if (req_seen && delay_left > 0)
      delay_left = delay_left - 1;
  end

  ////////////////////
  // reference rules
  ////////////////////

  function automatic int num_bytes(logic [1:0] size);
    return (size == 2'b00) ? 4 : (size == 2'b01) ? 2 : 1;
  endfunction

  // second beat takes the lanes that spilled past lane 3
  function automatic be_t exp_be(logic [1:0] size, byte_off_t off, bit second);
    be_t be;
    int  lane;
    be = '0;
    for (int k = 0; k < num_bytes(size); k++)
    begin
      lane = int'(off) + k;
      if (!second && lane < 4)
        be[lane] = 1'b1;
      if (second && lane >= 4)
        be[lane-4] = 1'b1;
    end
    return be;
  endfunction

  function automatic word_t exp_wdata(word_t src, byte_off_t off, byte_off_t reg_off);
    word_t w;
    int    r;
    for (int lane = 0; lane < 4; lane++)
    begin
      r = (lane - int'(off) + int'(reg_off) + 4) % 4; // register byte for this lane
      w[8*lane +: 8] = src[8*r +: 8];
    end
    return w;
  endfunction

  // little endian bytes from the model followed by upper fill
  function automatic word_t exp_load(addr_t addr, logic [1:0] size, logic [1:0] fill);
    word_t v;
    int    n;
    bit    fb;
    v = '0;
    n = num_bytes(size);
    for (int k = 0; k < n; k++)
      v[8*k +: 8] = mem[(addr + k) % 64];
    fb = (fill == 2'b00) ? 1'b0 : (fill == 2'b10) ? 1'b1 : v[8*n-1];
    for (int b = 8*n; b < 32; b++)
      v[b] = fb;
    return v;
  endfunction

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic fail_value(string name, word_t exp, word_t act);
    any_fail = 1'b1;
    $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    $display("Done: errors found");
    $fatal(1, "stopping at first mismatch");
  endtask

  task automatic check_be(string name, be_t exp, be_t act);
    if (exp !== act)
      fail_value({name, " be"}, word_t'(exp), word_t'(act));
  endtask

  task automatic check_wdata(string name, word_t exp, word_t act);
    if (exp !== act)
      fail_value({name, " wdata"}, exp, act);
  endtask

  task automatic check_rdata(string name, word_t exp, word_t act);
    if (exp !== act)
      fail_value({name, " rdata"}, exp, act);
  endtask

  task automatic check_flag(string name, bit exp, bit act);
    if (exp !== act)
      fail_value(name, word_t'(exp), word_t'(act));
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic set_entry(int i, string name, bit we, word_t a, word_t b, bit incr,
                           logic [1:0] size, logic [1:0] fill, byte_off_t ro, word_t wd, bit mis);
    tbl[i] = '{name, we, a, b, incr, size, fill, ro, wd, mis};
  endtask

  task automatic drive_part(entry_t e, addr_t addr, bit second);
    req_ex      = 1'b1;
    we_ex       = e.we;
    type_ex     = e.size;
    sign_ext_ex = e.fill;
    reg_off_ex  = e.reg_off;
    wdata_ex    = e.wdata;
    op_a_ex     = second ? addr + 32'd4 : e.op_a; // next word with the same low bits
    op_b_ex     = second ? '0 : e.op_b;
    useincr_ex  = second ? 1'b0 : e.incr;
    mis_ex      = second;
  endtask

  // beat checks at +2 ns and hold until grant
  task automatic run_part(entry_t e, addr_t addr, bit second);
    @(posedge clk);
    #1 drive_part(e, addr, second);
    #1;
    check_flag({e.name, " misaligned"}, second ? 1'b0 : e.mis, mis_o);
    check_be(e.name, exp_be(e.size, addr[1:0], second), data_be);
    if (e.we)
      check_wdata(e.name, exp_wdata(e.wdata, addr[1:0], e.reg_off), data_wdata);
    while (!data_gnt)
    begin
      check_flag({e.name, " req held"}, 1'b1, data_req);
      check_flag({e.name, " ready_ex"}, 1'b0, ready_ex);
      @(posedge clk);
      #2;
    end
  endtask

  initial
  begin
    repeat (LIMIT) @(posedge clk);
    $display("timeout: the test did not finish within %0d cycles", LIMIT);
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

  initial
  begin
    entry_t e;
    addr_t  addr;
    word_t  exp_val;
    word_t  exp_w;
    word_t  act_w;
    word_t  last_rdata;
    int     n;
    void'($urandom(55886));
    req_ex      = 1'b0;
    we_ex       = 1'b0;
    type_ex     = 2'b00;
    wdata_ex    = '0;
    reg_off_ex  = '0;
    sign_ext_ex = 2'b00;
    op_a_ex     = '0;
    op_b_ex     = '0;
    useincr_ex  = 1'b0;
    mis_ex      = 1'b0;
    data_rvalid = 1'b0;
    data_rdata  = '0;
    last_rdata  = '0; // result register resets to zero
    for (int i = 0; i < 64; i++)
      mem[i] = 8'(i * 29) ^ 8'ha5; // mixed msbs for sign fill
    // name, we, a, b, incr, size, fill, reg offset, wdata, misaligned
    set_entry(0, "st_w_0", 1, 32'h00, 0, 0, 2'b00, 2'b00, 0, 32'h11223344, 0);
    set_entry(1, "st_h_2", 1, 32'h04, 2, 1, 2'b01, 2'b00, 0, 32'haabbccdd, 0);
    set_entry(2, "st_b_1", 1, 32'h09, 0, 0, 2'b10, 2'b00, 2, 32'h55667788, 0);
    set_entry(3, "st_b_3", 1, 32'h0b, 0, 0, 2'b10, 2'b00, 0, 32'h000000f1, 0);
    set_entry(4, "st_h_1", 1, 32'h0d, 0, 0, 2'b01, 2'b00, 1, 32'h0bad0c0d, 0);
    set_entry(5, "st_w_2_mis", 1, 32'h10, 2, 1, 2'b00, 2'b00, 0, 32'hcafef00d, 1);
    set_entry(6, "st_h_3_mis", 1, 32'h17, 0, 0, 2'b01, 2'b00, 0, 32'h00001234, 1);
    set_entry(7, "ld_b_zero_0", 0, 32'h24, 0, 0, 2'b10, 2'b00, 0, 0, 0);
    set_entry(8, "ld_b_sign_1", 0, 32'h25, 0, 0, 2'b10, 2'b01, 0, 0, 0);
    set_entry(9, "ld_b_ones_2", 0, 32'h22, 0, 0, 2'b10, 2'b10, 0, 0, 0);
    set_entry(10, "ld_b_fill3_3", 0, 32'h23, 0, 0, 2'b10, 2'b11, 0, 0, 0);
    set_entry(11, "ld_size3_2", 0, 32'h2a, 0, 0, 2'b11, 2'b01, 0, 0, 0);
    set_entry(12, "ld_h_sign_0", 0, 32'h24, 0, 0, 2'b01, 2'b01, 0, 0, 0);
    set_entry(13, "ld_h_zero_1", 0, 32'h25, 0, 0, 2'b01, 2'b00, 0, 0, 0);
    set_entry(14, "ld_h_ones_2", 0, 32'h26, 0, 0, 2'b01, 2'b10, 0, 0, 0);
    set_entry(15, "ld_w_0", 0, 32'h28, 0, 0, 2'b00, 2'b00, 0, 0, 0);
    set_entry(16, "ld_w_1_mis", 0, 32'h29, 0, 0, 2'b00, 2'b00, 0, 0, 1);
    set_entry(17, "ld_w_3_mis", 0, 32'h2c, 3, 1, 2'b00, 2'b01, 0, 0, 1);
    set_entry(18, "ld_h_3_mis", 0, 32'h33, 0, 0, 2'b01, 2'b01, 0, 0, 1);
    set_entry(19, "ld_back_mis", 0, 32'h10, 2, 1, 2'b00, 2'b00, 0, 0, 1);

    wait (rst_n === 1'b1);
    @(posedge clk);
    #2;
    check_flag("reset busy", 1'b0, busy);
    check_flag("reset ready_ex", 1'b1, ready_ex);
    check_flag("reset ready_wb", 1'b1, ready_wb);

    for (int i = 0; i < NUM_ENTRIES; i++)
    begin
      e       = tbl[i];
      addr    = e.incr ? e.op_a + e.op_b : e.op_a;
      exp_val = exp_load(addr, e.size, e.fill); // memory before this access
      run_part(e, addr, 1'b0);
      if (e.mis)
        run_part(e, addr, 1'b1); // second beat starts in the first one's rvalid cycle
      @(posedge clk);
      #1 req_ex = 1'b0;
      mis_ex = 1'b0;
      #1;
      while (!data_rvalid)
      begin
        @(posedge clk);
        #2;
      end
      if (!e.we)
      begin
        check_rdata(e.name, exp_val, rdata_ex); // shown in the rvalid cycle
        last_rdata = exp_val;
      end
      @(posedge clk);
      #2;
      check_rdata({e.name, " hold"}, last_rdata, rdata_ex);
      check_flag({e.name, " busy"}, 1'b0, busy);
      if (e.we)
      begin
        n     = num_bytes(e.size);
        exp_w = '0;
        act_w = '0;
        for (int k = 0; k < n; k++)
        begin
          exp_w[8*k +: 8] = e.wdata[8*((int'(e.reg_off) + k) % 4) +: 8];
          act_w[8*k +: 8] = mem[(addr + k) % 64];
        end
        check_wdata({e.name, " memory"}, exp_w, act_w);
      end
    end

    if (!any_fail)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

/* list.f */
source/lsu_access_pkg.sv
source/lsu_bus_pkg.sv
source/lsu_load_ctx_if.sv
source/lsu_addr_store.sv
source/lsu_bus_ctrl.sv
source/lsu_load_align.sv
source/lsu_top.sv
verification/tb_clock_gen.sv
verification/tb_lsu.sv

/* Makefile */
# Verilator flow for the load/store unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module lsu_top -f list.f

sim:
	verilator --binary --timing --assert --top-module tb_lsu -f list.f -o sim_lsu
	./obj_dir/sim_lsu | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
